/* source/root_hub_pkg.sv */
`default_nettype none

package root_hub_pkg;

    // message layout on every hub stream
    localparam int MSG_WIDTH = 64;
    localparam int DEST_WIDTH = 8;
    localparam int PAYLOAD_WIDTH = MSG_WIDTH - DEST_WIDTH;

    // board id, 0 is the root and leaf i is i+1
    typedef logic [DEST_WIDTH-1:0] dest_t;

    // message body, opaque to the hub
    typedef logic [PAYLOAD_WIDTH-1:0] payload_t;

    // dest sits in the top byte
    typedef struct packed {
        dest_t    dest;
        payload_t payload;
    } hub_msg_t;

    // reserved id, reaches every leaf
    localparam dest_t BROADCAST_DEST = '1;

    // down path FSM
    typedef enum logic [0:0] {
        DISPATCH_IDLE  = 1'b0,
        DISPATCH_BCAST = 1'b1 // some leaves still owe a broadcast accept
    } dispatch_state_t;

endpackage

`default_nettype wire

/* source/hub_fifo.sv */
`default_nettype none

module hub_fifo #(
    parameter int DEPTH = 8,
    parameter int DELAY = 3
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire root_hub_pkg::hub_msg_t  in_msg_i,
    input  wire logic                    in_valid_i,
    output logic                         in_ready_o,
    output root_hub_pkg::hub_msg_t       out_msg_o,
    output logic                         out_valid_o,
    input  wire logic                    out_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    root_hub_pkg::hub_msg_t mem [DEPTH];
    logic [31:0]            stamp [DEPTH]; // cycle from which the entry counts as stored

    logic [31:0]      now_q;
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [31:0]      head_age;
    logic             push, pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign head_age = now_q - stamp[rd_ptr_q];

    assign in_ready_o  = (count_q != CNT_W'(DEPTH));
    assign out_valid_o = (count_q != '0) && (head_age >= 32'(DELAY));
    assign out_msg_o   = mem[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            now_q    <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            now_q <= now_q + 1'b1; // free running
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q]   <= in_msg_i;
            stamp[wr_ptr_q] <= now_q + 1'b1; // age 0 in the cycle after the write
        end
    end

endmodule

`default_nettype wire

/* source/leaf_link.sv */
`default_nettype none

module leaf_link #(
    parameter int FIFO_DEPTH = 8,
    parameter int ROUTER_DELAY = 3
) (
    input  wire logic                    clk,
    input  wire logic                    reset,

    // from the dispatcher
    input  wire root_hub_pkg::hub_msg_t  down_msg_i,
    input  wire logic                    down_valid_i,
    output logic                         down_ready_o,

    // towards the leaf board
    output root_hub_pkg::hub_msg_t       leaf_down_msg_o,
    output logic                         leaf_down_valid_o,
    input  wire logic                    leaf_down_ready_i,

    // from the leaf board
    input  wire root_hub_pkg::hub_msg_t  leaf_up_msg_i,
    input  wire logic                    leaf_up_valid_i,
    output logic                         leaf_up_ready_o,

    // towards the arbiter
    output root_hub_pkg::hub_msg_t       up_msg_o,
    output logic                         up_valid_o,
    input  wire logic                    up_ready_i
);

    // router distance towards the leaf
    hub_fifo #(
        .DEPTH(FIFO_DEPTH),
        .DELAY(ROUTER_DELAY)
    ) down_fifo_inst (
        .clk(clk),
        .reset(reset),
        .in_msg_i(down_msg_i),
        .in_valid_i(down_valid_i),
        .in_ready_o(down_ready_o),
        .out_msg_o(leaf_down_msg_o),
        .out_valid_o(leaf_down_valid_o),
        .out_ready_i(leaf_down_ready_i)
    );

    // and back up
    hub_fifo #(
        .DEPTH(FIFO_DEPTH),
        .DELAY(ROUTER_DELAY)
    ) up_fifo_inst (
        .clk(clk),
        .reset(reset),
        .in_msg_i(leaf_up_msg_i),
        .in_valid_i(leaf_up_valid_i),
        .in_ready_o(leaf_up_ready_o),
        .out_msg_o(up_msg_o),
        .out_valid_o(up_valid_o),
        .out_ready_i(up_ready_i)
    );

endmodule

`default_nettype wire

/* source/down_dispatcher.sv */
`default_nettype none

module down_dispatcher #(
    parameter int NUM_LEAVES = 4
) (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire root_hub_pkg::hub_msg_t  ctrl_msg_i,
    input  wire logic                    ctrl_valid_i,
    output logic                         ctrl_ready_o,
    output root_hub_pkg::hub_msg_t       down_msg_o,
    output logic [NUM_LEAVES-1:0]        down_valid_o,
    input  wire logic [NUM_LEAVES-1:0]   down_ready_i
);

    root_hub_pkg::dispatch_state_t state_q, state_d;
    logic [NUM_LEAVES-1:0]         pending_q, pending_d;
    logic [NUM_LEAVES-1:0]         still_pending;
    logic [NUM_LEAVES-1:0]         target;
    logic                          is_bcast, is_uni;

    assign is_bcast = (ctrl_msg_i.dest == root_hub_pkg::BROADCAST_DEST);
    assign is_uni   = (ctrl_msg_i.dest != '0)
                   && (ctrl_msg_i.dest <= root_hub_pkg::dest_t'(NUM_LEAVES));

    always_comb begin
        for (int i = 0; i < NUM_LEAVES; i++) begin
            target[i] = (ctrl_msg_i.dest == root_hub_pkg::dest_t'(i + 1));
        end
    end

    // all leaves see the same message, valid picks who takes it
    assign down_msg_o    = ctrl_msg_i;
    assign still_pending = pending_q & ~down_ready_i;

    always_comb begin
        state_d      = state_q;
        pending_d    = pending_q;
        down_valid_o = '0;
        ctrl_ready_o = 1'b0;
        case (state_q)
            root_hub_pkg::DISPATCH_IDLE: begin
                if (ctrl_valid_i) begin
                    if (is_bcast) begin
                        down_valid_o = '1;
                        if (&down_ready_i) begin
                            ctrl_ready_o = 1'b1;
                        end else begin
                            // ready leaves take it now, the rest later
                            state_d   = root_hub_pkg::DISPATCH_BCAST;
                            pending_d = ~down_ready_i;
                        end
                    end else if (is_uni) begin
                        down_valid_o = target;
                        ctrl_ready_o = |(target & down_ready_i);
                    end else begin
                        ctrl_ready_o = 1'b1; // bad dest, swallow it
                    end
                end
            end
            root_hub_pkg::DISPATCH_BCAST: begin
                down_valid_o = pending_q;
                pending_d    = still_pending;
                if (still_pending == '0) begin
                    ctrl_ready_o = 1'b1;
                    state_d      = root_hub_pkg::DISPATCH_IDLE;
                end
            end
            default: state_d = root_hub_pkg::DISPATCH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= root_hub_pkg::DISPATCH_IDLE;
            pending_q <= '0;
        end else begin
            state_q   <= state_d;
            pending_q <= pending_d;
        end
    end

endmodule

`default_nettype wire

/* source/up_arbiter.sv */
`default_nettype none

module up_arbiter #(
    parameter int NUM_LEAVES = 4
) (
    input  wire logic                                    clk,
    input  wire logic                                    reset,
    input  wire root_hub_pkg::hub_msg_t [NUM_LEAVES-1:0] up_msg_i,
    input  wire logic [NUM_LEAVES-1:0]                   up_valid_i,
    output logic [NUM_LEAVES-1:0]                        up_ready_o,
    output root_hub_pkg::hub_msg_t                       host_msg_o,
    output logic                                         host_valid_o,
    input  wire logic                                    host_ready_i
);

    localparam int IDX_W = (NUM_LEAVES > 1) ? $clog2(NUM_LEAVES) : 1;

    logic [IDX_W-1:0]       last_q;     // leaf granted most recently
    logic [IDX_W-1:0]       grant_idx;
    logic                   grant_found;
    logic                   take;
    logic                   valid_q;
    root_hub_pkg::hub_msg_t msg_q;

    // search starts one past the last winner
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_idx   = last_q;
        for (int k = 1; k <= NUM_LEAVES; k++) begin
            idx = (int'(last_q) + k) % NUM_LEAVES;
            if (!grant_found && up_valid_i[idx]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(idx);
            end
        end
    end

    assign take = !valid_q || host_ready_i; // stage empty or emptying

    always_comb begin
        up_ready_o = '0;
        if (take && grant_found) begin
            up_ready_o[grant_idx] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q  <= '0;
        end else if (take) begin
            valid_q <= grant_found;
            if (grant_found) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take && grant_found) begin
            msg_q.dest    <= root_hub_pkg::dest_t'(int'(grant_idx) + 1); // source tag
            msg_q.payload <= up_msg_i[grant_idx].payload;
        end
    end

    assign host_msg_o   = msg_q;
    assign host_valid_o = valid_q;

endmodule

`default_nettype wire

/* source/root_hub.sv */
`default_nettype none

module root_hub #(
    parameter int NUM_LEAVES = 4,
    parameter int FIFO_DEPTH = 8,
    parameter int ROUTER_DELAY = 3
) (
    input  wire logic                                    clk,
    input  wire logic                                    reset,

    // local controller side
    input  wire root_hub_pkg::hub_msg_t                  ctrl_msg_i,
    input  wire logic                                    ctrl_valid_i,
    output logic                                         ctrl_ready_o,
    output root_hub_pkg::hub_msg_t                       host_msg_o,
    output logic                                         host_valid_o,
    input  wire logic                                    host_ready_i,

    // leaf boards
    output root_hub_pkg::hub_msg_t [NUM_LEAVES-1:0]      leaf_down_msg_o,
    output logic [NUM_LEAVES-1:0]                        leaf_down_valid_o,
    input  wire logic [NUM_LEAVES-1:0]                   leaf_down_ready_i,
    input  wire root_hub_pkg::hub_msg_t [NUM_LEAVES-1:0] leaf_up_msg_i,
    input  wire logic [NUM_LEAVES-1:0]                   leaf_up_valid_i,
    output logic [NUM_LEAVES-1:0]                        leaf_up_ready_o
);

    root_hub_pkg::hub_msg_t                  down_msg;
    logic [NUM_LEAVES-1:0]                   down_valid, down_ready;
    root_hub_pkg::hub_msg_t [NUM_LEAVES-1:0] up_msg;
    logic [NUM_LEAVES-1:0]                   up_valid, up_ready;

    down_dispatcher #(
        .NUM_LEAVES(NUM_LEAVES)
    ) down_dispatcher_inst (
        .clk(clk),
        .reset(reset),
        .ctrl_msg_i(ctrl_msg_i),
        .ctrl_valid_i(ctrl_valid_i),
        .ctrl_ready_o(ctrl_ready_o),
        .down_msg_o(down_msg),
        .down_valid_o(down_valid),
        .down_ready_i(down_ready)
    );

    for (genvar i = 0; i < NUM_LEAVES; i++) begin : g_leaf
        leaf_link #(
            .FIFO_DEPTH(FIFO_DEPTH),
            .ROUTER_DELAY(ROUTER_DELAY)
        ) leaf_link_inst (
            .clk(clk),
            .reset(reset),
            .down_msg_i(down_msg),
            .down_valid_i(down_valid[i]),
            .down_ready_o(down_ready[i]),
            .leaf_down_msg_o(leaf_down_msg_o[i]),
            .leaf_down_valid_o(leaf_down_valid_o[i]),
            .leaf_down_ready_i(leaf_down_ready_i[i]),
            .leaf_up_msg_i(leaf_up_msg_i[i]),
            .leaf_up_valid_i(leaf_up_valid_i[i]),
            .leaf_up_ready_o(leaf_up_ready_o[i]),
            .up_msg_o(up_msg[i]),
            .up_valid_o(up_valid[i]),
            .up_ready_i(up_ready[i])
        );
    end

    up_arbiter #(
        .NUM_LEAVES(NUM_LEAVES)
    ) up_arbiter_inst (
        .clk(clk),
        .reset(reset),
        .up_msg_i(up_msg),
        .up_valid_i(up_valid),
        .up_ready_o(up_ready),
        .host_msg_o(host_msg_o),
        .host_valid_o(host_valid_o),
        .host_ready_i(host_ready_i)
    );

endmodule

`default_nettype wire

/* verif/root_hub_assertions.sv */
`default_nettype none

module root_hub_assertions #(
    parameter int NUM_LEAVES = 4
) (
    input wire logic                                    clk,
    input wire logic                                    reset,
    input wire root_hub_pkg::hub_msg_t                  host_msg_i,
    input wire logic                                    host_valid_i,
    input wire logic                                    host_ready_i,
    input wire root_hub_pkg::hub_msg_t [NUM_LEAVES-1:0] leaf_down_msg_i,
    input wire logic [NUM_LEAVES-1:0]                   leaf_down_valid_i,
    input wire logic [NUM_LEAVES-1:0]                   leaf_down_ready_i
);

    int failures = 0;

    // stalled host message must hold
    host_hold: assert property (@(posedge clk) disable iff (reset)
        host_valid_i && !host_ready_i |=> host_valid_i && $stable(host_msg_i))
        else begin $error("host stream changed a stalled message"); failures++; end

    for (genvar i = 0; i < NUM_LEAVES; i++) begin : g_leaf
        leaf_hold: assert property (@(posedge clk) disable iff (reset)
            leaf_down_valid_i[i] && !leaf_down_ready_i[i]
            |=> leaf_down_valid_i[i] && $stable(leaf_down_msg_i[i]))
            else begin $error("leaf %0d changed a stalled message", i); failures++; end
    end

    valids_cleared: assert property (@(posedge clk)
        reset |=> !host_valid_i && leaf_down_valid_i == '0)
        else begin $error("a valid was high right after reset"); failures++; end

endmodule

bind root_hub root_hub_assertions #(
    .NUM_LEAVES(NUM_LEAVES)
) root_hub_assertions_inst (
    .clk(clk),
    .reset(reset),
    .host_msg_i(host_msg_o),
    .host_valid_i(host_valid_o),
    .host_ready_i(host_ready_i),
    .leaf_down_msg_i(leaf_down_msg_o),
    .leaf_down_valid_i(leaf_down_valid_o),
    .leaf_down_ready_i(leaf_down_ready_i)
);

`default_nettype wire

/* verif/root_hub_tb.sv */
`default_nettype none

module root_hub_tb;

    localparam int NUM_LEAVES = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int ROUTER_DELAY = 3;
    localparam int NUM_TESTS = 6;
    localparam int MSGS_PER_TEST = 48;
    localparam int CYCLES_PER_MSG = 100; // worst case incl. long host stalls
    localparam int DRAIN_CYCLES = 300;

    // ready patterns
    localparam int MODE_HIGH = 0;
    localparam int MODE_RANDOM = 1;
    localparam int MODE_STALLS = 2;
    localparam int MODE_LOW = 3;

    logic                                    clk, reset;
    root_hub_pkg::hub_msg_t                  ctrl_msg, host_msg;
    logic                                    ctrl_valid, ctrl_ready, host_valid, host_ready;
    root_hub_pkg::hub_msg_t [NUM_LEAVES-1:0] leaf_down_msg, leaf_up_msg;
    logic [NUM_LEAVES-1:0]                   leaf_down_valid, leaf_down_ready;
    logic [NUM_LEAVES-1:0]                   leaf_up_valid, leaf_up_ready;

    root_hub_pkg::hub_msg_t down_exp [NUM_LEAVES][$]; // routed, not yet seen at the leaf
    root_hub_pkg::hub_msg_t up_sent [NUM_LEAVES][$];  // taken from a leaf, not yet at host

    integer seed = 29;
    int     errors = 0;
    int     checks = 0;
    int     test_errors;
    int     down_mode, host_mode, host_stall;
    logic   saw_up_stall;

    root_hub #(
        .NUM_LEAVES(NUM_LEAVES),
        .FIFO_DEPTH(FIFO_DEPTH),
        .ROUTER_DELAY(ROUTER_DELAY)
    ) root_hub_inst (
        .clk(clk),
        .reset(reset),
        .ctrl_msg_i(ctrl_msg),
        .ctrl_valid_i(ctrl_valid),
        .ctrl_ready_o(ctrl_ready),
        .host_msg_o(host_msg),
        .host_valid_o(host_valid),
        .host_ready_i(host_ready),
        .leaf_down_msg_o(leaf_down_msg),
        .leaf_down_valid_o(leaf_down_valid),
        .leaf_down_ready_i(leaf_down_ready),
        .leaf_up_msg_i(leaf_up_msg),
        .leaf_up_valid_i(leaf_up_valid),
        .leaf_up_ready_o(leaf_up_ready)
    );

    always #5 clk = ~clk;

    initial begin
        #(NUM_TESTS * MSGS_PER_TEST * CYCLES_PER_MSG * 10);
        $display("timeout: the tests did not finish within the cycle budget");
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic root_hub_pkg::hub_msg_t rand_msg(input root_hub_pkg::dest_t dest);
        logic [63:0] r;
        r = {$random(seed), $random(seed)};
        rand_msg.dest    = dest;
        rand_msg.payload = r[55:0];
    endfunction

    always @(negedge clk) begin
        case (down_mode)
            MODE_HIGH:   leaf_down_ready = '1;
            MODE_RANDOM: leaf_down_ready = NUM_LEAVES'($random(seed));
            default:     leaf_down_ready = '0;
        endcase
        if (host_stall > 0) begin
            host_ready = 1'b0;
            host_stall--;
        end else if (host_mode == MODE_STALLS && rand_below(8) == 0) begin
            host_stall = 30 + rand_below(31); // long stall
            host_ready = 1'b0;
        end else begin
            host_ready = (host_mode == MODE_HIGH || host_mode == MODE_STALLS)
                      || (host_mode == MODE_RANDOM && rand_below(2) == 0);
        end
    end

    // transfers seen at the leaves and at the host
    always @(posedge clk) begin
        root_hub_pkg::hub_msg_t exp_msg;
        int src;
        if (!reset) begin
            for (int i = 0; i < NUM_LEAVES; i++) begin
                if (leaf_down_valid[i] && leaf_down_ready[i]) begin
                    checks++;
                    assert (down_exp[i].size() != 0) else begin
                        $display("t=%0t leaf %0d got a message never routed to it", $time, i);
                        errors++;
                    end
                    if (down_exp[i].size() != 0) begin
                        exp_msg = down_exp[i].pop_front();
                        assert (leaf_down_msg[i] == exp_msg) else begin
                            $display("FAIL t=%0t leaf_down_msg_o[%0d] expected %h got %h",
                                     $time, i, exp_msg, leaf_down_msg[i]);
                            errors++;
                        end
                    end
                end
            end
            if (host_valid && host_ready) begin
                checks++;
                src = int'(host_msg.dest) - 1; // source tag is leaf+1
                assert (src >= 0 && src < NUM_LEAVES && up_sent[src].size() != 0) else begin
                    $display("t=%0t host got a message with no outstanding source, dest %h",
                             $time, host_msg.dest);
                    errors++;
                end
                if (src >= 0 && src < NUM_LEAVES && up_sent[src].size() != 0) begin
                    exp_msg = up_sent[src].pop_front();
                    assert (host_msg.payload == exp_msg.payload) else begin
                        $display("FAIL t=%0t host_msg_o.payload expected %h got %h",
                                 $time, exp_msg.payload, host_msg.payload);
                        errors++;
                    end
                end
            end
            if (!host_ready && leaf_up_ready != '1) begin
                saw_up_stall = 1'b1;
            end
        end
    end

    task automatic send_ctrl(input root_hub_pkg::hub_msg_t msg);
        int d;
        d = int'(msg.dest);
        @(negedge clk);
        ctrl_msg   = msg;
        ctrl_valid = 1'b1;
        // a broadcast can reach a fast leaf before the slowest one accepts
        if (d == 255) begin
            for (int i = 0; i < NUM_LEAVES; i++) begin
                down_exp[i].push_back(msg);
            end
        end else if (d >= 1 && d <= NUM_LEAVES) begin
            down_exp[d - 1].push_back(msg);
        end // anything else is dropped
        do begin
            @(posedge clk);
        end while (!ctrl_ready);
        @(negedge clk);
        ctrl_valid = 1'b0;
    endtask

    task automatic send_up(input int leaf, input root_hub_pkg::hub_msg_t msg);
        @(negedge clk);
        leaf_up_msg[leaf]   = msg;
        leaf_up_valid[leaf] = 1'b1;
        do begin
            @(posedge clk);
        end while (!leaf_up_ready[leaf]);
        up_sent[leaf].push_back(msg);
        @(negedge clk);
        leaf_up_valid[leaf] = 1'b0;
    endtask

    task automatic up_stream(input int leaf, input int n);
        for (int k = 0; k < n; k++) begin
            repeat (rand_below(3)) @(negedge clk);
            send_up(leaf, rand_msg(8'(rand_below(256))));
        end
    endtask

    // every leaf sends n messages at once
    task automatic run_up_traffic(input int n);
        for (int l = 0; l < NUM_LEAVES; l++) begin
            automatic int leaf = l;
            fork
                up_stream(leaf, n);
            join_none
        end
        wait fork;
    endtask

    task automatic drain();
        int left;
        @(posedge clk);
        down_mode  = MODE_HIGH;
        host_mode  = MODE_HIGH;
        host_stall = 0;
        for (int c = 0; c < DRAIN_CYCLES; c++) begin
            left = 0;
            for (int i = 0; i < NUM_LEAVES; i++) begin
                left += down_exp[i].size() + up_sent[i].size();
            end
            if (left == 0) break;
            @(posedge clk);
        end
        for (int i = 0; i < NUM_LEAVES; i++) begin
            assert (down_exp[i].size() == 0 && up_sent[i].size() == 0) else begin
                $display("t=%0t leaf %0d still owes %0d down and %0d up messages",
                         $time, i, down_exp[i].size(), up_sent[i].size());
                errors++;
            end
        end
        repeat (ROUTER_DELAY + 4) @(posedge clk); // late extras show up here
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic send_unicast_burst(input int n);
        for (int k = 0; k < n; k++) begin
            send_ctrl(rand_msg(8'(1 + rand_below(NUM_LEAVES))));
        end
    endtask

    task automatic test_reset_state();
        down_mode = MODE_LOW;
        host_mode = MODE_LOW;
        for (int k = 0; k < NUM_LEAVES; k++) begin
            send_ctrl(rand_msg(8'(k + 1)));
        end
        run_up_traffic(2);
        repeat (ROUTER_DELAY + 2) @(negedge clk);
        reset = 1'b1; // stuck traffic gets flushed
        for (int i = 0; i < NUM_LEAVES; i++) begin
            down_exp[i].delete();
            up_sent[i].delete();
        end
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        checks += 2;
        assert (host_valid == 1'b0) else begin
            $display("FAIL t=%0t host_valid_o expected 0 got %b", $time, host_valid);
            errors++;
        end
        assert (leaf_down_valid == '0) else begin
            $display("FAIL t=%0t leaf_down_valid_o expected 0 got %b", $time, leaf_down_valid);
            errors++;
        end
        down_mode = MODE_RANDOM;
        host_mode = MODE_RANDOM;
        fork
            send_unicast_burst(MSGS_PER_TEST / 2);
            run_up_traffic(MSGS_PER_TEST / (2 * NUM_LEAVES));
        join
        drain();
        report_test(6, "reset state");
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        ctrl_msg        = '0;
        ctrl_valid      = 1'b0;
        host_ready      = 1'b0;
        leaf_down_ready = '0;
        leaf_up_msg     = '0;
        leaf_up_valid   = '0;
        down_mode       = MODE_LOW;
        host_mode       = MODE_LOW;
        host_stall      = 0;
        saw_up_stall    = 1'b0;
        test_errors     = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);

        down_mode = MODE_HIGH;
        host_mode = MODE_HIGH;
        send_unicast_burst(MSGS_PER_TEST);
        drain();
        report_test(1, "unicast routing");

        down_mode = MODE_RANDOM;
        for (int k = 0; k < MSGS_PER_TEST; k++) begin
            send_ctrl(rand_msg(8'hff));
        end
        drain();
        report_test(2, "broadcast under back-pressure");

        down_mode = MODE_RANDOM;
        for (int k = 0; k < MSGS_PER_TEST; k++) begin
            case (rand_below(3))
                0:       send_ctrl(rand_msg(8'h00));
                1:       send_ctrl(rand_msg(8'(5 + rand_below(250)))); // 5 to 254
                default: send_ctrl(rand_msg(8'(1 + rand_below(NUM_LEAVES))));
            endcase
        end
        drain();
        report_test(3, "invalid destinations");

        run_up_traffic(MSGS_PER_TEST / NUM_LEAVES);
        drain();
        report_test(4, "up merge and tagging");

        saw_up_stall = 1'b0;
        host_mode    = MODE_STALLS;
        host_stall   = 80; // long enough to fill the up FIFOs
        run_up_traffic(MSGS_PER_TEST / NUM_LEAVES);
        checks++;
        assert (saw_up_stall) else begin
            $display("leaf_up_ready_o never dropped while the host was stalled");
            errors++;
        end
        drain();
        report_test(5, "host back-pressure");

        test_reset_state();

        errors += root_hub_inst.root_hub_assertions_inst.failures;
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/root_hub_pkg.sv
source/hub_fifo.sv
source/leaf_link.sv
source/down_dispatcher.sv
source/up_arbiter.sv
source/root_hub.sv
verif/root_hub_assertions.sv
verif/root_hub_tb.sv

/* Bender.yml */
package:
  name: root_hub

sources:
  - source/root_hub_pkg.sv
  - source/hub_fifo.sv
  - source/leaf_link.sv
  - source/down_dispatcher.sv
  - source/up_arbiter.sv
  - source/root_hub.sv
  - target: test
    files:
      - verif/root_hub_assertions.sv
      - verif/root_hub_tb.sv
